// ==== hw/StorePkg.sv ====
package StorePkg;

    // The top bit of a physical tag marks a special tag that reads as zero
    localparam int TAG_W = 6;

    localparam int SQN_W = 8;

    localparam int DATA_W = 32;

    // Indexed by the low five tag bits
    localparam int NUM_REGS = 32;

    localparam int MASK_W = 4;

    typedef enum logic [1:0] {
        StByte = 2'd0,
        StHalf = 2'd1,
        StWord = 2'd2
    } StSize;

    // Byte offset within the word
    typedef logic [1:0] StOff;

    function automatic logic isSpecialTag(input logic [TAG_W-1:0] tag);
        return tag[TAG_W-1];
    endfunction

    // True if a is younger than b, using the wrapped difference
    function automatic logic isYounger(input logic [SQN_W-1:0] a, input logic [SQN_W-1:0] b);
        logic [SQN_W-1:0] diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

// ==== hw/PriorityEncoder.sv ====
`timescale 1ns/1ps

module PriorityEncoder #(
    parameter int SIZE = 8
) (
    input  logic [SIZE-1:0]         req,
    output logic [$clog2(SIZE)-1:0] idx,
    output logic                    valid
);

    // Scan from the top so the lowest set bit wins
    always_comb begin
        idx = '0;
        for (int i = SIZE - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = i[$clog2(SIZE)-1:0];
            end
        end
    end

    assign valid = |req;

endmodule

// ==== hw/StoreDataIQ.sv ====
`timescale 1ns/1ps

module StoreDataIQ #(
    parameter int SIZE = 8,
    parameter int NUM_DISPATCH = 2
) (
    input  logic                                           clk,
    input  logic                                           rst,

    input  logic [NUM_DISPATCH-1:0]                        dispValid,
    input  logic [NUM_DISPATCH-1:0][StorePkg::TAG_W-1:0]   dispTag,
    input  logic [NUM_DISPATCH-1:0][StorePkg::SQN_W-1:0]   dispSqN,
    input  StorePkg::StSize [NUM_DISPATCH-1:0]             dispSize,
    output logic [NUM_DISPATCH-1:0]                        stall,

    input  logic                                           resValid,
    input  logic [StorePkg::TAG_W-1:0]                     resTag,

    input  logic                                           aguValid,
    input  logic [StorePkg::SQN_W-1:0]                     aguSqN,
    input  logic [StorePkg::DATA_W-1:0]                    aguBase,
    input  logic [StorePkg::DATA_W-1:0]                    aguImm,
    input  StorePkg::StSize                                aguSize,

    input  logic                                           brTaken,
    input  logic [StorePkg::SQN_W-1:0]                     brSqN,
    input  logic                                           brFlush,

    input  logic [StorePkg::SQN_W-1:0]                     maxStoreSqN,

    input  logic                                           issReady,
    output logic                                           issValid,
    output logic [StorePkg::TAG_W-1:0]                     issTag,
    output logic [StorePkg::SQN_W-1:0]                     issSqN,
    output StorePkg::StOff                                 issOff,
    output StorePkg::StSize                                issSize,

    output logic                                           comLimitValid,
    output logic [StorePkg::SQN_W-1:0]                     comLimitSqN
);

    localparam int ID_W = $clog2(SIZE);

    // Position 0 holds the oldest queue entry
    logic [StorePkg::TAG_W-1:0] qTag [SIZE];
    logic [StorePkg::SQN_W-1:0] qSqN [SIZE];
    StorePkg::StSize            qSize [SIZE];
    StorePkg::StOff             qOff [SIZE];
    logic [SIZE-1:0]            qDataAvail;
    logic [SIZE-1:0]            qOffAvail;

    logic [ID_W:0] insertIndex;
    logic [ID_W:0] nextInsert;
    logic [ID_W:0] brIndex;

    logic            resWake;
    StorePkg::StOff  aguOff;
    logic            aguSnoop;
    logic [SIZE-1:0] newData;
    logic [SIZE-1:0] newOffAvail;
    StorePkg::StOff  newOff [SIZE];

    logic [SIZE-1:0] deqReq;
    logic [ID_W-1:0] deqIdx;
    logic            deqValid;
    logic            doIssue;

    logic [NUM_DISPATCH-1:0] enq;
    logic [ID_W-1:0]         enqPos [NUM_DISPATCH];

    assign resWake  = resValid && !StorePkg::isSpecialTag(resTag);
    assign aguOff   = StorePkg::StOff'(aguBase + aguImm);
    assign aguSnoop = aguValid && (aguSize != StorePkg::StWord);

    // Result wakeup and address offset snoop
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            newData[i] = resWake && (qTag[i] == resTag);
            newOffAvail[i] = aguSnoop && (qSqN[i] == aguSqN);
            newOff[i] = newOffAvail[i] ? aguOff : qOff[i];
        end
    end

    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            deqReq[i] = (i < int'(insertIndex)) && qDataAvail[i] && qOffAvail[i] &&
                !StorePkg::isYounger(qSqN[i], maxStoreSqN);
        end
    end

    PriorityEncoder #(
        .SIZE(SIZE)
    ) i_deqEnc (
        .req  (deqReq),
        .idx  (deqIdx),
        .valid(deqValid)
    );

    assign doIssue = !brTaken && (issReady || !issValid) && deqValid;

    // Keep everything up to the last entry not younger than the branch
    always_comb begin
        brIndex = '0;
        for (int i = 0; i < SIZE; i++) begin
            if (i < int'(insertIndex) && !brFlush && !StorePkg::isYounger(qSqN[i], brSqN)) begin
                brIndex = (ID_W + 1)'(i + 1);
            end
        end
    end

    // Dispatch acceptance, counting earlier lanes of the same cycle
    always_comb begin
        logic [ID_W:0] qIdx;
        logic [ID_W:0] slot;
        qIdx = insertIndex;
        slot = insertIndex - (ID_W + 1)'(doIssue);
        for (int l = 0; l < NUM_DISPATCH; l++) begin
            stall[l] = 1'b0;
            enq[l] = 1'b0;
            enqPos[l] = slot[ID_W-1:0];
            if (dispValid[l]) begin
                if (qIdx != (ID_W + 1)'(SIZE) && !brTaken) begin
                    enq[l] = 1'b1;
                    qIdx = qIdx + 1'b1;
                    slot = slot + 1'b1;
                end else begin
                    stall[l] = 1'b1;
                end
            end
        end
        nextInsert = brTaken ? brIndex : slot;
    end

    // Entry payload shifts toward position 0 on issue
    always_ff @(posedge clk) begin
        for (int i = 0; i < SIZE; i++) begin
            qDataAvail[i] <= qDataAvail[i] | newData[i];
            qOffAvail[i] <= qOffAvail[i] | newOffAvail[i];
            qOff[i] <= newOff[i];
        end
        if (doIssue) begin
            for (int i = 0; i < SIZE - 1; i++) begin
                if (i >= int'(deqIdx)) begin
                    qTag[i] <= qTag[i+1];
                    qSqN[i] <= qSqN[i+1];
                    qSize[i] <= qSize[i+1];
                    qOff[i] <= newOff[i+1];
                    qDataAvail[i] <= qDataAvail[i+1] | newData[i+1];
                    qOffAvail[i] <= qOffAvail[i+1] | newOffAvail[i+1];
                end
            end
        end
        for (int l = 0; l < NUM_DISPATCH; l++) begin
            if (enq[l]) begin
                qTag[enqPos[l]] <= dispTag[l];
                qSqN[enqPos[l]] <= dispSqN[l];
                qSize[enqPos[l]] <= dispSize[l];
                // Word stores need no offset
                qOff[enqPos[l]] <= '0;
                qOffAvail[enqPos[l]] <= (dispSize[l] == StorePkg::StWord);
                qDataAvail[enqPos[l]] <= resWake && (dispTag[l] == resTag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            insertIndex <= '0;
        end else begin
            insertIndex <= nextInsert;
        end
    end

    // Issue register
    always_ff @(posedge clk) begin
        if (rst) begin
            issValid <= 1'b0;
        end else if (brTaken) begin
            // Consumed by the read stage this cycle or made younger by the branch
            if (issReady || brFlush || StorePkg::isYounger(issSqN, brSqN)) begin
                issValid <= 1'b0;
            end
        end else if (issReady || !issValid) begin
            issValid <= deqValid;
            issTag <= qTag[deqIdx];
            issSqN <= qSqN[deqIdx];
            issOff <= newOff[deqIdx];
            issSize <= qSize[deqIdx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            comLimitValid <= 1'b0;
        end else begin
            comLimitValid <= (insertIndex != '0);
        end
        comLimitSqN <= qSqN[0];
    end

endmodule

// ==== hw/ResultRegFile.sv ====
`timescale 1ns/1ps

module ResultRegFile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          resValid,
    input  logic [StorePkg::TAG_W-1:0]    resTag,
    input  logic [StorePkg::DATA_W-1:0]   resData,
    input  logic [StorePkg::TAG_W-1:0]    rdTag,
    output logic [StorePkg::DATA_W-1:0]   rdData
);

    localparam int IDX_W = $clog2(StorePkg::NUM_REGS);

    logic [StorePkg::DATA_W-1:0] regs [StorePkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < StorePkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (resValid && !StorePkg::isSpecialTag(resTag)) begin
            regs[resTag[IDX_W-1:0]] <= resData;
        end
    end

    // Writes show up the cycle after, without bypass
    always_comb begin
        if (StorePkg::isSpecialTag(rdTag)) begin
            rdData = '0;
        end else begin
            rdData = regs[rdTag[IDX_W-1:0]];
        end
    end

endmodule

// ==== hw/StoreDataRead.sv ====
`timescale 1ns/1ps

module StoreDataRead (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          issValid,
    input  logic [StorePkg::TAG_W-1:0]    issTag,
    input  logic [StorePkg::SQN_W-1:0]    issSqN,
    input  StorePkg::StOff                issOff,
    input  StorePkg::StSize               issSize,
    output logic                          issReady,

    output logic [StorePkg::TAG_W-1:0]    rdTag,
    input  logic [StorePkg::DATA_W-1:0]   rdData,

    input  logic                          sqReady,
    input  logic                          brTaken,
    input  logic [StorePkg::SQN_W-1:0]    brSqN,
    input  logic                          brFlush,

    output logic                          sqWrValid,
    output logic [StorePkg::SQN_W-1:0]    sqWrSqN,
    output logic [StorePkg::DATA_W-1:0]   sqWrData,
    output logic [StorePkg::MASK_W-1:0]   sqWrMask
);

    logic [StorePkg::DATA_W-1:0] shiftData;
    logic [StorePkg::MASK_W-1:0] mask;
    logic                        issKill;
    logic                        heldKill;

    assign rdTag = issTag;
    assign issReady = !sqWrValid || sqReady;

    assign shiftData = rdData << {issOff, 3'b000};

    always_comb begin
        case (issSize)
            StorePkg::StByte: mask = StorePkg::MASK_W'(4'b0001) << issOff;
            StorePkg::StHalf: mask = StorePkg::MASK_W'(4'b0011) << issOff;
            default:          mask = StorePkg::MASK_W'(4'b1111);
        endcase
    end

    assign issKill  = brTaken && (brFlush || StorePkg::isYounger(issSqN, brSqN));
    assign heldKill = brTaken && (brFlush || StorePkg::isYounger(sqWrSqN, brSqN));

    always_ff @(posedge clk) begin
        if (rst) begin
            sqWrValid <= 1'b0;
        end else begin
            if ((sqWrValid && sqReady) || heldKill) begin
                sqWrValid <= 1'b0;
            end
            if (issValid && issReady && !issKill) begin
                sqWrValid <= 1'b1;
            end
        end
        if (issValid && issReady && !issKill) begin
            sqWrSqN <= issSqN;
            sqWrData <= shiftData;
            sqWrMask <= mask;
        end
    end

endmodule

// ==== hw/StoreDataUnit.sv ====
`timescale 1ns/1ps

module StoreDataUnit #(
    parameter int SIZE = 8,
    parameter int NUM_DISPATCH = 2
) (
    input  logic                                           clk,
    input  logic                                           rst,

    input  logic [NUM_DISPATCH-1:0]                        dispValid,
    input  logic [NUM_DISPATCH-1:0][StorePkg::TAG_W-1:0]   dispTag,
    input  logic [NUM_DISPATCH-1:0][StorePkg::SQN_W-1:0]   dispSqN,
    input  StorePkg::StSize [NUM_DISPATCH-1:0]             dispSize,
    output logic [NUM_DISPATCH-1:0]                        stall,

    input  logic                                           resValid,
    input  logic [StorePkg::TAG_W-1:0]                     resTag,
    input  logic [StorePkg::DATA_W-1:0]                    resData,

    input  logic                                           aguValid,
    input  logic [StorePkg::SQN_W-1:0]                     aguSqN,
    input  logic [StorePkg::DATA_W-1:0]                    aguBase,
    input  logic [StorePkg::DATA_W-1:0]                    aguImm,
    input  StorePkg::StSize                                aguSize,

    input  logic                                           brTaken,
    input  logic [StorePkg::SQN_W-1:0]                     brSqN,
    input  logic                                           brFlush,

    input  logic [StorePkg::SQN_W-1:0]                     maxStoreSqN,
    input  logic                                           sqReady,

    output logic                                           comLimitValid,
    output logic [StorePkg::SQN_W-1:0]                     comLimitSqN,

    output logic                                           sqWrValid,
    output logic [StorePkg::SQN_W-1:0]                     sqWrSqN,
    output logic [StorePkg::DATA_W-1:0]                    sqWrData,
    output logic [StorePkg::MASK_W-1:0]                    sqWrMask
);

    logic                        issValid;
    logic                        issReady;
    logic [StorePkg::TAG_W-1:0]  issTag;
    logic [StorePkg::SQN_W-1:0]  issSqN;
    StorePkg::StOff              issOff;
    StorePkg::StSize             issSize;
    logic [StorePkg::TAG_W-1:0]  rdTag;
    logic [StorePkg::DATA_W-1:0] rdData;

    StoreDataIQ #(
        .SIZE        (SIZE),
        .NUM_DISPATCH(NUM_DISPATCH)
    ) i_iq (
        .clk          (clk),
        .rst          (rst),
        .dispValid    (dispValid),
        .dispTag      (dispTag),
        .dispSqN      (dispSqN),
        .dispSize     (dispSize),
        .stall        (stall),
        .resValid     (resValid),
        .resTag       (resTag),
        .aguValid     (aguValid),
        .aguSqN       (aguSqN),
        .aguBase      (aguBase),
        .aguImm       (aguImm),
        .aguSize      (aguSize),
        .brTaken      (brTaken),
        .brSqN        (brSqN),
        .brFlush      (brFlush),
        .maxStoreSqN  (maxStoreSqN),
        .issReady     (issReady),
        .issValid     (issValid),
        .issTag       (issTag),
        .issSqN       (issSqN),
        .issOff       (issOff),
        .issSize      (issSize),
        .comLimitValid(comLimitValid),
        .comLimitSqN  (comLimitSqN)
    );

    ResultRegFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .resValid(resValid),
        .resTag  (resTag),
        .resData (resData),
        .rdTag   (rdTag),
        .rdData  (rdData)
    );

    StoreDataRead i_read (
        .clk      (clk),
        .rst      (rst),
        .issValid (issValid),
        .issTag   (issTag),
        .issSqN   (issSqN),
        .issOff   (issOff),
        .issSize  (issSize),
        .issReady (issReady),
        .rdTag    (rdTag),
        .rdData   (rdData),
        .sqReady  (sqReady),
        .brTaken  (brTaken),
        .brSqN    (brSqN),
        .brFlush  (brFlush),
        .sqWrValid(sqWrValid),
        .sqWrSqN  (sqWrSqN),
        .sqWrData (sqWrData),
        .sqWrMask (sqWrMask)
    );

endmodule

// ==== verification/StoreDataTb.sv ====
`timescale 1ns/1ps

module StoreDataTb;

    localparam int SIZE = 8;

    logic                                 clk;
    logic                                 rst;
    logic [1:0]                           dispValid;
    logic [1:0][StorePkg::TAG_W-1:0]      dispTag;
    logic [1:0][StorePkg::SQN_W-1:0]      dispSqN;
    StorePkg::StSize [1:0]                dispSize;
    logic [1:0]                           stall;
    logic                                 resValid;
    logic [StorePkg::TAG_W-1:0]           resTag;
    logic [31:0]                          resData;
    logic                                 aguValid;
    logic [7:0]                           aguSqN;
    logic [31:0]                          aguBase;
    logic [31:0]                          aguImm;
    StorePkg::StSize                      aguSize;
    logic                                 brTaken;
    logic [7:0]                           brSqN;
    logic                                 brFlush;
    logic [7:0]                           maxStoreSqN;
    logic                                 sqReady;
    logic                                 comLimitValid;
    logic [7:0]                           comLimitSqN;
    logic                                 sqWrValid;
    logic [7:0]                           sqWrSqN;
    logic [31:0]                          sqWrData;
    logic [3:0]                           sqWrMask;

    // Expected store-queue writes keyed by sequence number
    logic        expValid [256];
    logic [31:0] expData [256];
    logic [3:0]  expMask [256];
    int          pending;

    logic [31:0] rngState;
    logic [7:0]  seq;
    string       curTest;
    int          errCount;
    int          testErrs;
    int          testCount;

    StoreDataUnit #(
        .SIZE        (SIZE),
        .NUM_DISPATCH(2)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .dispValid    (dispValid),
        .dispTag      (dispTag),
        .dispSqN      (dispSqN),
        .dispSize     (dispSize),
        .stall        (stall),
        .resValid     (resValid),
        .resTag       (resTag),
        .resData      (resData),
        .aguValid     (aguValid),
        .aguSqN       (aguSqN),
        .aguBase      (aguBase),
        .aguImm       (aguImm),
        .aguSize      (aguSize),
        .brTaken      (brTaken),
        .brSqN        (brSqN),
        .brFlush      (brFlush),
        .maxStoreSqN  (maxStoreSqN),
        .sqReady      (sqReady),
        .comLimitValid(comLimitValid),
        .comLimitSqN  (comLimitSqN),
        .sqWrValid    (sqWrValid),
        .sqWrSqN      (sqWrSqN),
        .sqWrData     (sqWrData),
        .sqWrMask     (sqWrMask)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic logic [StorePkg::TAG_W-1:0] tagOf(input logic [7:0] sqn);
        return StorePkg::TAG_W'(sqn[4:0]);
    endfunction

    // Writes are taken when the store queue is ready; outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!rst && sqWrValid && sqReady) begin
            if (!expValid[sqWrSqN]) begin
                $display("ERROR %s: unexpected store-queue write for sqN %0d", curTest, sqWrSqN);
                errCount++;
            end else begin
                if (sqWrData !== expData[sqWrSqN]) begin
                    $display("ERROR %s: sqWrData for sqN %0d expected %h actual %h",
                             curTest, sqWrSqN, expData[sqWrSqN], sqWrData);
                    errCount++;
                end
                if (sqWrMask !== expMask[sqWrSqN]) begin
                    $display("ERROR %s: sqWrMask for sqN %0d expected %b actual %b",
                             curTest, sqWrSqN, expMask[sqWrSqN], sqWrMask);
                    errCount++;
                end
                expValid[sqWrSqN] = 1'b0;
                pending--;
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    // Data moves up by whole bytes; the mask covers the store's bytes from the offset
    task automatic expectStore(input logic [7:0] sqn, input logic [31:0] value,
                               input StorePkg::StSize size, input logic [1:0] off);
        logic [31:0] d;
        logic [3:0]  m;
        int          nBytes;
        d = value;
        for (int b = 0; b < int'(off); b++) begin
            d = {d[23:0], 8'h00};
        end
        nBytes = (size == StorePkg::StByte) ? 1 : (size == StorePkg::StHalf) ? 2 : 4;
        for (int b = 0; b < 4; b++) begin
            m[b] = (b >= int'(off)) && (b < int'(off) + nBytes);
        end
        if (!expValid[sqn]) begin
            pending++;
        end
        expValid[sqn] = 1'b1;
        expData[sqn] = d;
        expMask[sqn] = m;
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrs = errCount;
        testCount++;
        for (int i = 0; i < 256; i++) begin
            expValid[i] = 1'b0;
        end
        pending = 0;
    endtask

    task automatic endTest();
        if (errCount == testErrs) begin
            $display("%s: ok", curTest);
        end else begin
            $display("%s: %0d errors", curTest, errCount - testErrs);
        end
    endtask

    task automatic driveStore(input int lane, input logic [7:0] sqn, input StorePkg::StSize size);
        dispValid[lane] = 1'b1;
        dispTag[lane] = tagOf(sqn);
        dispSqN[lane] = sqn;
        dispSize[lane] = size;
    endtask

    task automatic driveResult(input logic [7:0] sqn, input logic [31:0] value);
        resValid = 1'b1;
        resTag = tagOf(sqn);
        resData = value;
    endtask

    task automatic clearInputs();
        dispValid = '0;
        resValid = 1'b0;
    endtask

    task automatic dispatchStore(input logic [7:0] sqn, input StorePkg::StSize size,
                                 input logic withResult, input logic [31:0] value);
        int n;
        n = 0;
        driveStore(0, sqn, size);
        if (withResult) begin
            driveResult(sqn, value);
        end
        #1;
        while (stall[0] && n < 50) begin
            @(posedge clk);
            #3;
            n++;
        end
        if (stall[0]) begin
            $display("%s: dispatch of sqN %0d stalled too long", curTest, sqn);
            errCount++;
        end
        tick();
        clearInputs();
    endtask

    task automatic broadcast(input logic [7:0] sqn, input logic [31:0] value);
        driveResult(sqn, value);
        tick();
        resValid = 1'b0;
    endtask

    task automatic snoop(input logic [7:0] sqn, input logic [31:0] base, input logic [31:0] imm,
                         input StorePkg::StSize size);
        aguValid = 1'b1;
        aguSqN = sqn;
        aguBase = base;
        aguImm = imm;
        aguSize = size;
        tick();
        aguValid = 1'b0;
    endtask

    task automatic branch(input logic [7:0] sqn, input logic flush);
        brTaken = 1'b1;
        brSqN = sqn;
        brFlush = flush;
        tick();
        brTaken = 1'b0;
        brFlush = 1'b0;
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (pending != 0 && n < 200) begin
            tick();
            n++;
        end
        if (pending != 0) begin
            $display("%s: timed out with %0d store-queue writes missing", curTest, pending);
            errCount++;
        end
    endtask

    task automatic waitWrValid();
        int n;
        n = 0;
        while (!sqWrValid && n < 50) begin
            tick();
            n++;
        end
        if (!sqWrValid) begin
            $display("%s: timed out waiting for a store-queue write", curTest);
            errCount++;
        end
    endtask

    task automatic testWordStores();
        logic [31:0] v [6];
        logic [7:0]  s;
        startTest("wordStores");
        s = seq;
        seq = s + 8'd6;
        for (int i = 0; i < 6; i++) begin
            v[i] = nextRand();
            expectStore(s + 8'(i), v[i], StorePkg::StWord, 2'd0);
        end
        // Result on the bus in the dispatch cycle
        for (int i = 0; i < 3; i++) begin
            dispatchStore(s + 8'(i), StorePkg::StWord, 1'b1, v[i]);
        end
        for (int i = 3; i < 6; i++) begin
            dispatchStore(s + 8'(i), StorePkg::StWord, 1'b0, 32'h0);
        end
        for (int i = 3; i < 6; i++) begin
            broadcast(s + 8'(i), v[i]);
        end
        waitDrain();
        endTest();
    endtask

    task automatic testByteHalf();
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] vc;
        logic [7:0]  s;
        startTest("byteHalfStores");
        s = seq;
        seq = s + 8'd3;
        va = nextRand();
        vb = nextRand();
        vc = nextRand();
        expectStore(s + 8'd2, vc, StorePkg::StWord, 2'd0);
        dispatchStore(s, StorePkg::StByte, 1'b1, va);
        dispatchStore(s + 8'd1, StorePkg::StHalf, 1'b1, vb);
        dispatchStore(s + 8'd2, StorePkg::StWord, 1'b1, vc);
        waitDrain();
        // Byte and half stores must still be waiting here
        idle(8);
        // 0x1001 + 2 and 0x2ffe + 4 end in offsets 3 and 2
        expectStore(s, va, StorePkg::StByte, 2'd3);
        snoop(s, 32'h0000_1001, 32'd2, StorePkg::StByte);
        expectStore(s + 8'd1, vb, StorePkg::StHalf, 2'd2);
        snoop(s + 8'd1, 32'h0000_2ffe, 32'd4, StorePkg::StHalf);
        waitDrain();
        endTest();
    endtask

    task automatic testCommitLimit();
        logic [31:0] v [4];
        logic [7:0]  s;
        startTest("commitLimit");
        s = seq;
        seq = s + 8'd4;
        maxStoreSqN = s + 8'd1;
        for (int i = 0; i < 4; i++) begin
            v[i] = nextRand();
            if (i < 2) begin
                expectStore(s + 8'(i), v[i], StorePkg::StWord, 2'd0);
            end
            dispatchStore(s + 8'(i), StorePkg::StWord, 1'b1, v[i]);
        end
        waitDrain();
        idle(6);
        if (!comLimitValid) begin
            $display("%s: comLimitValid low with stores still queued", curTest);
            errCount++;
        end else if (comLimitSqN !== s + 8'd2) begin
            $display("ERROR %s: comLimitSqN expected %0d actual %0d",
                     curTest, s + 8'd2, comLimitSqN);
            errCount++;
        end
        expectStore(s + 8'd2, v[2], StorePkg::StWord, 2'd0);
        expectStore(s + 8'd3, v[3], StorePkg::StWord, 2'd0);
        maxStoreSqN = 8'd120;
        waitDrain();
        idle(2);
        if (comLimitValid) begin
            $display("%s: comLimitValid high with an empty queue", curTest);
            errCount++;
        end
        endTest();
    endtask

    task automatic testBackPressure();
        logic [31:0] v;
        logic [7:0]  s;
        int          accepted;
        logic        sawStall;
        logic [43:0] held;
        startTest("backPressure");
        s = seq;
        accepted = 0;
        sawStall = 1'b0;
        sqReady = 1'b0;
        for (int i = 0; i < 16 && !sawStall; i++) begin
            v = nextRand();
            driveStore(0, s + 8'(accepted), StorePkg::StWord);
            driveResult(s + 8'(accepted), v);
            #1;
            if (stall[0]) begin
                sawStall = 1'b1;
                clearInputs();
            end else begin
                expectStore(s + 8'(accepted), v, StorePkg::StWord, 2'd0);
                accepted++;
                tick();
                clearInputs();
            end
        end
        tick();
        seq = s + 8'(accepted);
        if (!sawStall) begin
            $display("%s: stall never rose with the store queue blocked", curTest);
            errCount++;
        end
        if (accepted != SIZE + 2) begin
            $display("ERROR %s: accepted stores expected %0d actual %0d",
                     curTest, SIZE + 2, accepted);
            errCount++;
        end
        held = {sqWrSqN, sqWrData, sqWrMask};
        idle(4);
        if (!sqWrValid || {sqWrSqN, sqWrData, sqWrMask} !== held) begin
            $display("%s: store-queue write changed or dropped under back-pressure", curTest);
            errCount++;
        end
        sqReady = 1'b1;
        waitDrain();
        endTest();
    endtask

    task automatic testMispredict();
        logic [31:0] v;
        logic [7:0]  s;
        startTest("mispredict");
        s = seq;
        seq = s + 8'd6;
        sqReady = 1'b0;
        for (int i = 0; i < 6; i++) begin
            v = nextRand();
            if (i < 3) begin
                expectStore(s + 8'(i), v, StorePkg::StWord, 2'd0);
            end
            dispatchStore(s + 8'(i), StorePkg::StWord, 1'b1, v);
        end
        waitWrValid();
        // Oldest in the read stage, next in the issue register, rest queued
        branch(s + 8'd2, 1'b0);
        sqReady = 1'b1;
        waitDrain();
        idle(8);
        s = seq;
        seq = s + 8'd4;
        sqReady = 1'b0;
        for (int i = 0; i < 4; i++) begin
            dispatchStore(s + 8'(i), StorePkg::StWord, 1'b1, nextRand());
        end
        waitWrValid();
        branch(8'd0, 1'b1);
        if (sqWrValid) begin
            $display("%s: store-queue write still valid after a flush", curTest);
            errCount++;
        end
        tick();
        if (comLimitValid) begin
            $display("%s: comLimitValid still high after a flush", curTest);
            errCount++;
        end
        sqReady = 1'b1;
        idle(8);
        endTest();
    endtask

    task automatic testTwoLane();
        logic [31:0] va;
        logic [31:0] vb;
        logic [7:0]  s;
        startTest("twoLane");
        s = seq;
        va = nextRand();
        vb = nextRand();
        expectStore(s, va, StorePkg::StWord, 2'd0);
        expectStore(s + 8'd1, vb, StorePkg::StWord, 2'd0);
        driveStore(0, s, StorePkg::StWord);
        driveStore(1, s + 8'd1, StorePkg::StWord);
        driveResult(s, va);
        #1;
        if (stall !== 2'b00) begin
            $display("ERROR %s: stall expected 00 actual %b", curTest, stall);
            errCount++;
        end
        tick();
        clearInputs();
        broadcast(s + 8'd1, vb);
        waitDrain();
        // Fill both stage registers and all but one queue slot
        s = s + 8'd2;
        sqReady = 1'b0;
        for (int i = 0; i <= SIZE; i++) begin
            va = nextRand();
            expectStore(s + 8'(i), va, StorePkg::StWord, 2'd0);
            dispatchStore(s + 8'(i), StorePkg::StWord, 1'b1, va);
        end
        va = nextRand();
        driveStore(0, s + 8'd9, StorePkg::StWord);
        driveStore(1, s + 8'd10, StorePkg::StWord);
        driveResult(s + 8'd9, va);
        #1;
        if (stall !== 2'b10) begin
            $display("ERROR %s: stall expected 10 actual %b", curTest, stall);
            errCount++;
        end
        expectStore(s + 8'd9, va, StorePkg::StWord, 2'd0);
        tick();
        clearInputs();
        seq = s + 8'd11;
        sqReady = 1'b1;
        waitDrain();
        idle(4);
        endTest();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dispValid = '0;
        dispTag = '0;
        dispSqN = '0;
        dispSize[0] = StorePkg::StWord;
        dispSize[1] = StorePkg::StWord;
        resValid = 1'b0;
        resTag = '0;
        resData = '0;
        aguValid = 1'b0;
        aguSqN = '0;
        aguBase = '0;
        aguImm = '0;
        aguSize = StorePkg::StByte;
        brTaken = 1'b0;
        brSqN = '0;
        brFlush = 1'b0;
        maxStoreSqN = 8'd120;
        sqReady = 1'b1;
        rngState = 32'h146c_5794;
        seq = 8'd1;
        curTest = "reset";
        errCount = 0;
        testErrs = 0;
        testCount = 0;
        pending = 0;
        for (int i = 0; i < 256; i++) begin
            expValid[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        tick();

        testWordStores();
        testByteHalf();
        testCommitLimit();
        testBackPressure();
        testMispredict();
        testTwoLane();

        $display("%0d tests run, %0d errors", testCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/StorePkg.sv
hw/PriorityEncoder.sv
hw/StoreDataIQ.sv
hw/ResultRegFile.sv
hw/StoreDataRead.sv
hw/StoreDataUnit.sv
verification/StoreDataTb.sv

// ==== Makefile ====
# Verilator build and run for the store-data unit testbench

TOP = StoreDataTb

.PHONY: all lint clean

# Build, run, then decide pass or fail from the log
all:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	@grep -q "^TESTS PASSED" sim.log && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
